// File: hdl/ocp_pkg.sv
`default_nettype none

package ocp_pkg;

  // MCmd encoding
  // Only IDLE, WR and RD are issued by this master
  typedef enum logic [2:0] {
    IDLE = 3'b000,
    WR   = 3'b001,
    RD   = 3'b010,
    RDEX = 3'b011,
    RDL  = 3'b100,
    WRNP = 3'b101,
    WRC  = 3'b110,
    BCST = 3'b111
  } ocp_cmd_e;

  // SResp encoding
  typedef enum logic [1:0] {
    NULL = 2'b00,
    DVA  = 2'b01,
    FAIL = 2'b10,
    ERR  = 2'b11
  } ocp_resp_e;

  // MBurstSeq encoding
  // Anything but INCR keeps the address fixed
  typedef enum logic [2:0] {
    INCR  = 3'b000,
    DFLT1 = 3'b001,
    WRAP  = 3'b010,
    DFLT2 = 3'b011,
    XOR   = 3'b100,
    STRM  = 3'b101,
    UNKN  = 3'b110,
    BLCK  = 3'b111
  } ocp_burst_seq_e;

endpackage

`default_nettype wire

// File: hdl/master_cfg_pkg.sv
`default_nettype none

package master_cfg_pkg;

  // Byte address width on OCP
  localparam int ADDR_W = 32;

  // Word width of MData and SData
  // Byte enables are one bit per byte of this
  localparam int DATA_W = 64;

  // MBurstLength width, bursts of 1 to 1023 beats
  localparam int LEN_W = 10;

endpackage

`default_nettype wire

// File: hdl/ocp_req_if.sv
`default_nettype none

interface ocp_req_if #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 64,
  parameter int LEN_W  = 10
);

  // One OCP request beat
  ocp_pkg::ocp_cmd_e       cmd;
  logic [ADDR_W-1:0]       addr;
  logic [DATA_W-1:0]       data;
  logic [DATA_W/8-1:0]     byte_en;
  logic [LEN_W-1:0]        burst_length;
  ocp_pkg::ocp_burst_seq_e burst_seq;
  logic                    req_last;

  // Command owner, ends the burst on the last beat
  modport fsm (output cmd, input req_last);

  // Beat counting
  modport counter (output req_last);

  // Address and field registers
  modport datapath (output addr, data, byte_en, burst_length, burst_seq);

  // Pins toward the slave
  modport bus (input cmd, addr, data, byte_en, burst_length, burst_seq, req_last);

endinterface

`default_nettype wire

// File: hdl/ocp_burst_fsm.sv
`default_nettype none

module ocp_burst_fsm (
  input  wire logic Clk,
  input  wire logic reset,
  input  wire logic read_request,
  input  wire logic write_request,
  input  wire logic cmd_accept,
  output logic      load,
  output logic      advance,
  output logic      busy,
  ocp_req_if.fsm    bus
);

  // High for the cycle after the last beat was accepted
  logic burst_tail;

  // New request only once the previous burst has fully wound down
  assign load = (bus.cmd == ocp_pkg::IDLE) && !busy && (read_request || write_request);

  // Beat handshake completes this cycle
  assign advance = (bus.cmd != ocp_pkg::IDLE) && cmd_accept;

  // Busy lingers one cycle past the return to IDLE
  assign busy = (bus.cmd != ocp_pkg::IDLE) || burst_tail;

  // State lives in MCmd itself
  always_ff @(posedge Clk) begin
    if (reset) begin
      bus.cmd <= ocp_pkg::IDLE;
    end else begin
      case (bus.cmd)
        ocp_pkg::IDLE: begin
          // Read wins when both arrive together
          if (load && read_request) begin
            bus.cmd <= ocp_pkg::RD;
          end else if (load) begin
            bus.cmd <= ocp_pkg::WR;
          end
        end
        ocp_pkg::WR, ocp_pkg::RD: begin
          if (advance && bus.req_last) begin
            bus.cmd <= ocp_pkg::IDLE;
          end
        end
        default: begin
          bus.cmd <= ocp_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge Clk) begin
    if (reset) begin
      burst_tail <= 1'b0;
    end else begin
      burst_tail <= advance && bus.req_last;
    end
  end

  // Pending beat keeps its command until the slave takes it
  a_cmd_hold: assert property (@(posedge Clk) disable iff (reset)
    (bus.cmd != ocp_pkg::IDLE && !cmd_accept) |=> $stable(bus.cmd));

endmodule

`default_nettype wire

// File: hdl/burst_counter.sv
`default_nettype none

module burst_counter #(
  parameter int LEN_W = 10
) (
  input  wire logic             Clk,
  input  wire logic             reset,
  input  wire logic             load,
  input  wire logic             advance,
  input  wire logic [LEN_W-1:0] burst_length,
  ocp_req_if.counter            bus
);

  // Accepted beats so far in this burst
  logic [LEN_W-1:0] count;
  // Burst length captured at request time
  logic [LEN_W-1:0] len_q;

  always_ff @(posedge Clk) begin
    if (reset) begin
      count <= '0;
      len_q <= '0;
    end else if (load) begin
      count <= '0;
      len_q <= burst_length;
    end else if (advance) begin
      count <= count + 1'b1;
    end
  end

  // Final beat of the burst
  assign bus.req_last = (count == len_q - 1'b1);

  // FSM must stop issuing once the last beat goes out
  a_count_range: assert property (@(posedge Clk) disable iff (reset)
    advance |-> (count < len_q));

endmodule

`default_nettype wire

// File: hdl/req_datapath.sv
`default_nettype none

module req_datapath #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 64,
  parameter int LEN_W  = 10
) (
  input  wire logic                    Clk,
  input  wire logic                    reset,
  input  wire logic                    load,
  input  wire logic                    advance,
  input  wire logic [ADDR_W-1:0]       address,
  input  wire logic [LEN_W-1:0]        burst_length,
  input  wire ocp_pkg::ocp_burst_seq_e burst_seq,
  input  wire logic [DATA_W/8-1:0]     valid_bytes,
  input  wire logic [DATA_W-1:0]       write_data,
  ocp_req_if.datapath                  bus
);

  // Bytes per beat, also the INCR address step
  localparam int BE_W = DATA_W / 8;

  logic [ADDR_W-1:0]       addr_q;
  logic [BE_W-1:0]         be_q;
  logic [LEN_W-1:0]        len_q;
  ocp_pkg::ocp_burst_seq_e seq_q;

  // Burst descriptor
  always_ff @(posedge Clk) begin
    if (reset) begin
      len_q <= '0;
      seq_q <= ocp_pkg::INCR;
    end else if (load) begin
      len_q <= burst_length;
      seq_q <= burst_seq;
    end
  end

  // Beat address and byte lanes
  always_ff @(posedge Clk) begin
    if (load) begin
      addr_q <= address;
      be_q   <= valid_bytes;
    end else if (advance && seq_q == ocp_pkg::INCR) begin
      // Next word, STRM and the rest hold the address
      addr_q <= addr_q + ADDR_W'(BE_W);
    end
  end

  assign bus.addr         = addr_q;
  assign bus.byte_en      = be_q;
  assign bus.burst_length = len_q;
  assign bus.burst_seq    = seq_q;

  // Bridge holds each word until beat_accept
  assign bus.data = write_data;

endmodule

`default_nettype wire

// File: hdl/resp_forward.sv
`default_nettype none

module resp_forward #(
  parameter int DATA_W = 64
) (
  input  wire logic               Clk,
  input  wire logic               reset,
  input  wire ocp_pkg::ocp_resp_e sresp,
  input  wire logic [DATA_W-1:0]  sdata,
  input  wire logic               sresp_last,
  output logic                    resp_accept,
  output logic                    tvalid,
  output logic [DATA_W-1:0]       tdata,
  output logic                    tuser,
  output logic                    tlast,
  input  wire logic               tready,
  output logic                    resp_error
);

  // Response handshake completes this cycle
  logic take;
  // Taken response carries data for the stream
  logic fwd;

  // Room when empty or when the held beat leaves now
  assign resp_accept = !tvalid || tready;

  assign take = (sresp != ocp_pkg::NULL) && resp_accept;
  assign fwd  = take && (sresp == ocp_pkg::DVA || sresp == ocp_pkg::FAIL);

  // Holding register occupancy
  always_ff @(posedge Clk) begin
    if (reset) begin
      tvalid <= 1'b0;
    end else if (fwd) begin
      tvalid <= 1'b1;
    end else if (tready) begin
      tvalid <= 1'b0;
    end
  end

  // Held beat
  always_ff @(posedge Clk) begin
    if (fwd) begin
      tdata <= sdata;
      tuser <= (sresp == ocp_pkg::FAIL);
      tlast <= sresp_last;
    end
  end

  // ERR only raises the flag, cleared by reset alone
  always_ff @(posedge Clk) begin
    if (reset) begin
      resp_error <= 1'b0;
    end else if (take && sresp == ocp_pkg::ERR) begin
      resp_error <= 1'b1;
    end
  end

  // Stalled beat keeps its payload
  a_stream_hold: assert property (@(posedge Clk) disable iff (reset)
    (tvalid && !tready) |=> ($stable(tdata) && $stable(tuser) && $stable(tlast)));

endmodule

`default_nettype wire

// File: hdl/ocp_master.sv
`default_nettype none

module ocp_master #(
  parameter int ADDR_W = master_cfg_pkg::ADDR_W,
  parameter int DATA_W = master_cfg_pkg::DATA_W,
  parameter int LEN_W  = master_cfg_pkg::LEN_W
) (
  input  wire logic                    Clk,
  input  wire logic                    reset,
  // Bridge side
  input  wire logic                    read_request,
  input  wire logic                    write_request,
  input  wire logic [ADDR_W-1:0]       address,
  input  wire logic [LEN_W-1:0]        burst_length,
  input  wire ocp_pkg::ocp_burst_seq_e burst_seq,
  input  wire logic [DATA_W/8-1:0]     valid_bytes,
  input  wire logic [DATA_W-1:0]       write_data,
  output logic                         busy,
  output logic                         beat_accept,
  // OCP request group
  output ocp_pkg::ocp_cmd_e            MCmd,
  output logic [ADDR_W-1:0]            MAddr,
  output logic [DATA_W-1:0]            MData,
  output logic [DATA_W/8-1:0]          MByteEn,
  output logic [LEN_W-1:0]             MBurstLength,
  output ocp_pkg::ocp_burst_seq_e      MBurstSeq,
  output logic                         MReqLast,
  input  wire logic                    SCmdAccept,
  // OCP response group
  input  wire ocp_pkg::ocp_resp_e      SResp,
  input  wire logic [DATA_W-1:0]       SData,
  input  wire logic                    SRespLast,
  output logic                         MRespAccept,
  // Response stream
  output logic                         s_axis_tvalid,
  output logic [DATA_W-1:0]            s_axis_tdata,
  output logic                         s_axis_tuser,
  output logic                         s_axis_tlast,
  input  wire logic                    s_axis_tready,
  // Sticky ERR flag
  output logic                         resp_error
);

  logic load;
  logic advance;

  ocp_req_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .LEN_W(LEN_W)) req_if ();

  ocp_burst_fsm i_ocp_burst_fsm (
    .Clk(Clk), .reset(reset),
    .read_request(read_request), .write_request(write_request),
    .cmd_accept(SCmdAccept),
    .load(load), .advance(advance), .busy(busy),
    .bus(req_if.fsm)
  );

  burst_counter #(.LEN_W(LEN_W)) i_burst_counter (
    .Clk(Clk), .reset(reset), .load(load), .advance(advance),
    .burst_length(burst_length), .bus(req_if.counter)
  );

  req_datapath #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .LEN_W(LEN_W)) i_req_datapath (
    .Clk(Clk), .reset(reset), .load(load), .advance(advance),
    .address(address), .burst_length(burst_length), .burst_seq(burst_seq),
    .valid_bytes(valid_bytes), .write_data(write_data),
    .bus(req_if.datapath)
  );

  resp_forward #(.DATA_W(DATA_W)) i_resp_forward (
    .Clk(Clk), .reset(reset),
    .sresp(SResp), .sdata(SData), .sresp_last(SRespLast), .resp_accept(MRespAccept),
    .tvalid(s_axis_tvalid), .tdata(s_axis_tdata), .tuser(s_axis_tuser),
    .tlast(s_axis_tlast), .tready(s_axis_tready), .resp_error(resp_error)
  );

  // Request group out to the pins
  assign MCmd         = req_if.cmd;
  assign MAddr        = req_if.addr;
  assign MData        = req_if.data;
  assign MByteEn      = req_if.byte_en;
  assign MBurstLength = req_if.burst_length;
  assign MBurstSeq    = req_if.burst_seq;
  assign MReqLast     = req_if.req_last;

  // Bridge moves to its next word
  assign beat_accept = advance;

endmodule

`default_nettype wire

// File: tb/ocp_slave_model.sv
`default_nettype none

module ocp_slave_model #(
  parameter int              ADDR_W   = 32,
  parameter int              DATA_W   = 64,
  parameter logic [63:0]     RD_KEY   = 64'h0,
  parameter int              ERR_BEAT = 0
) (
  input  wire logic               Clk,
  input  wire logic               reset,
  input  wire ocp_pkg::ocp_cmd_e  MCmd,
  input  wire logic [ADDR_W-1:0]  MAddr,
  input  wire logic               MReqLast,
  output logic                    SCmdAccept,
  output ocp_pkg::ocp_resp_e      SResp,
  output logic [DATA_W-1:0]       SData,
  output logic                    SRespLast,
  input  wire logic               MRespAccept,
  output logic                    s_axis_tready
);
  timeunit 1ns;
  timeprecision 1ps;

  integer seed = 32'hce3a_306d;

  // Pending responses, one per accepted beat
  ocp_pkg::ocp_resp_e resp_q[$];
  logic [DATA_W-1:0]  data_q[$];
  logic               last_q[$];
  // Read beats accepted so far
  int rd_n = 0;

  initial begin
    SCmdAccept = 1'b0;
    SResp = ocp_pkg::NULL;
    SData = '0;
    SRespLast = 1'b0;
    s_axis_tready = 1'b0;
  end

  // Sample both handshakes at the rising edge
  always @(posedge Clk) begin
    if (!reset) begin
      // Front entry is what is shown on SResp
      if (SResp != ocp_pkg::NULL && MRespAccept) begin
        void'(resp_q.pop_front());
        void'(data_q.pop_front());
        void'(last_q.pop_front());
      end
      if (MCmd != ocp_pkg::IDLE && SCmdAccept) begin
        last_q.push_back(MReqLast);
        if (MCmd == ocp_pkg::RD) begin
          data_q.push_back(DATA_W'(MAddr) ^ RD_KEY);
          if (rd_n == ERR_BEAT) begin
            resp_q.push_back(ocp_pkg::ERR);
          end else if (rd_n % 5 == 3) begin
            resp_q.push_back(ocp_pkg::FAIL);
          end else begin
            resp_q.push_back(ocp_pkg::DVA);
          end
          rd_n++;
        end else begin
          // Write acknowledge carries no data
          data_q.push_back('0);
          resp_q.push_back(ocp_pkg::DVA);
        end
      end
    end
  end

  // Outputs change on the falling edge
  always @(negedge Clk) begin
    if (reset) begin
      SCmdAccept = 1'b0;
      SResp = ocp_pkg::NULL;
      s_axis_tready = 1'b0;
    end else begin
      SCmdAccept = ($random(seed) % 4) != 0;
      s_axis_tready = ($random(seed) & 1) != 0;
      if (resp_q.size() > 0) begin
        SResp = resp_q[0];
        SData = data_q[0];
        SRespLast = last_q[0];
      end else begin
        SResp = ocp_pkg::NULL;
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/ocp_master_tb.sv
`default_nettype none

module ocp_master_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          ADDR_W     = master_cfg_pkg::ADDR_W;
  localparam int          DATA_W     = master_cfg_pkg::DATA_W;
  localparam int          LEN_W      = master_cfg_pkg::LEN_W;
  localparam logic [63:0] RD_KEY     = 64'h5a5a_0f0f_c3c3_9696;
  localparam int          ERR_BEAT   = 9;
  localparam int          WAIT_LIMIT = 2000;

  logic Clk = 1'b0;
  logic reset = 1'b1;
  logic read_request, write_request, busy, beat_accept;
  logic [ADDR_W-1:0] address, MAddr;
  logic [LEN_W-1:0] burst_length, MBurstLength;
  ocp_pkg::ocp_burst_seq_e burst_seq, MBurstSeq;
  logic [DATA_W/8-1:0] valid_bytes, MByteEn;
  logic [DATA_W-1:0] write_data, MData, SData, s_axis_tdata;
  ocp_pkg::ocp_cmd_e MCmd;
  ocp_pkg::ocp_resp_e SResp;
  logic MReqLast, SCmdAccept, SRespLast, MRespAccept;
  logic s_axis_tvalid, s_axis_tuser, s_axis_tlast, s_axis_tready, resp_error;

  integer seed = 32'hce3a_306d;
  int err_cnt = 0;
  int exp_cnt = 0;
  int stream_cnt = 0;
  int beat_k = 0;
  int acc_cnt = 0;
  int rd_n = 0;
  logic err_seen = 1'b0;
  logic timed_out = 1'b0;

  // Current burst as requested
  logic [ADDR_W-1:0] cur_base = '0;
  logic [LEN_W-1:0] cur_len = '0;
  ocp_pkg::ocp_burst_seq_e cur_seq = ocp_pkg::INCR;
  logic [ADDR_W-1:0] exp_addr;
  logic [DATA_W-1:0] wr_words [0:15];
  // Expected stream beats in order
  logic [DATA_W-1:0] exp_tdata [0:255];
  logic exp_tuser [0:255];
  logic exp_tlast [0:255];

  ocp_master #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .LEN_W(LEN_W)) i_ocp_master (.*);

  ocp_slave_model #(
    .ADDR_W(ADDR_W), .DATA_W(DATA_W), .RD_KEY(RD_KEY), .ERR_BEAT(ERR_BEAT)
  ) i_slave (.*);

  initial begin
    forever #20 Clk = ~Clk;
  end

  assign exp_addr = cur_base +
    ((cur_seq == ocp_pkg::INCR) ? ADDR_W'(beat_k * (DATA_W / 8)) : ADDR_W'(0));

  // Beat index, pulse count, stream progress, ERR seen
  always @(posedge Clk) begin
    if (!reset) begin
      if (!busy && (read_request || write_request)) begin
        beat_k <= 0;
        acc_cnt <= 0;
      end else begin
        if (MCmd != ocp_pkg::IDLE && SCmdAccept) beat_k <= beat_k + 1;
        if (beat_accept) acc_cnt <= acc_cnt + 1;
      end
      if (s_axis_tvalid && s_axis_tready) stream_cnt <= stream_cnt + 1;
      if (SResp == ocp_pkg::ERR && MRespAccept) err_seen <= 1'b1;
    end
  end

  // Bridge presents the word of the current beat
  always @(negedge Clk) begin
    write_data = wr_words[beat_k[3:0]];
  end

  a_reset_state: assert property (@(posedge Clk) $fell(reset) |->
      (MCmd == ocp_pkg::IDLE && !busy && !beat_accept && !s_axis_tvalid && !resp_error))
    else begin
      err_cnt++;
      $display("Error: %0t outputs not idle after reset", $time);
    end

  a_beat_fields: assert property (@(posedge Clk) disable iff (reset)
      (MCmd != ocp_pkg::IDLE) |-> (MAddr == exp_addr && MBurstLength == cur_len &&
      MBurstSeq == cur_seq && MReqLast == (beat_k == int'(cur_len) - 1)))
    else begin
      err_cnt++;
      $display("Error: %0t beat %0d fields wrong", $time, beat_k);
    end

  a_burst_end: assert property (@(posedge Clk) disable iff (reset)
      (MCmd != ocp_pkg::IDLE && SCmdAccept && MReqLast) |=> (MCmd == ocp_pkg::IDLE))
    else begin
      err_cnt++;
      $display("Error: %0t MCmd not IDLE after last beat", $time);
    end

  a_write_beat: assert property (@(posedge Clk) disable iff (reset)
      (MCmd == ocp_pkg::WR) |-> (MData == wr_words[beat_k[3:0]] && MByteEn == valid_bytes))
    else begin
      err_cnt++;
      $display("Error: %0t write data or byte enables wrong", $time);
    end

  // Full holding register with a stalled stream refuses responses
  a_resp_backpressure: assert property (@(posedge Clk) disable iff (reset)
      (s_axis_tvalid && !s_axis_tready) |-> !MRespAccept)
    else begin
      err_cnt++;
      $display("Error: %0t MRespAccept high under stream back-pressure", $time);
    end

  a_stream_beat: assert property (@(posedge Clk) disable iff (reset)
      s_axis_tvalid |-> (stream_cnt < exp_cnt && s_axis_tdata == exp_tdata[stream_cnt[7:0]] &&
      s_axis_tuser == exp_tuser[stream_cnt[7:0]] && s_axis_tlast == exp_tlast[stream_cnt[7:0]]))
    else begin
      err_cnt++;
      $display("Error: %0t stream beat %0d wrong", $time, stream_cnt);
    end

  a_error_flag: assert property (@(posedge Clk) disable iff (reset) resp_error == err_seen)
    else begin
      err_cnt++;
      $display("Error: %0t resp_error is %0b", $time, resp_error);
    end

  task automatic note_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    timed_out = 1'b1;
  endtask

  task automatic expect_stream(input logic [DATA_W-1:0] data, input logic user,
                               input logic last);
    exp_tdata[exp_cnt] = data;
    exp_tuser[exp_cnt] = user;
    exp_tlast[exp_cnt] = last;
    exp_cnt++;
  endtask

  // One bridge request, then wait for the burst to finish
  task automatic issue_burst(input logic is_rd, input logic [ADDR_W-1:0] base,
                             input int len, input ocp_pkg::ocp_burst_seq_e seq);
    int k;
    int t;
    logic [ADDR_W-1:0] a;
    if (timed_out) return;
    @(negedge Clk);
    cur_base = base;
    cur_len = LEN_W'(len);
    cur_seq = seq;
    for (k = 0; k < len; k++) begin
      wr_words[k] = {$random(seed), $random(seed)};
      a = base + ((seq == ocp_pkg::INCR) ? ADDR_W'(k * (DATA_W / 8)) : ADDR_W'(0));
      if (!is_rd) begin
        expect_stream('0, 1'b0, k == len - 1);
      end else begin
        // ERR beat leaves no trace on the stream
        if (rd_n != ERR_BEAT) expect_stream(DATA_W'(a) ^ RD_KEY, rd_n % 5 == 3, k == len - 1);
        rd_n++;
      end
    end
    address = base;
    burst_length = cur_len;
    burst_seq = seq;
    valid_bytes = 8'($random(seed));
    read_request = is_rd;
    write_request = !is_rd;
    @(negedge Clk);
    read_request = 1'b0;
    write_request = 1'b0;
    t = 0;
    while (busy && t < WAIT_LIMIT) begin
      @(negedge Clk);
      t++;
    end
    if (busy) begin
      note_timeout("end of burst");
    end else if (acc_cnt != len) begin
      err_cnt++;
      $display("Error: %0t beat_accept count %0d, expected %0d", $time, acc_cnt, len);
    end
  endtask

  initial begin
    int t;
    for (t = 0; t < 16; t++) wr_words[t] = '0;
    read_request = 1'b0;
    write_request = 1'b0;
    address = '0;
    burst_length = '0;
    burst_seq = ocp_pkg::INCR;
    valid_bytes = '0;
    write_data = '0;
    repeat (3) @(posedge Clk);
    @(negedge Clk);
    reset = 1'b0;

    issue_burst(1'b0, 32'h0000_1000, 4, ocp_pkg::INCR);
    issue_burst(1'b1, 32'h0000_2040, 8, ocp_pkg::INCR);
    issue_burst(1'b1, 32'h0000_3000, 3, ocp_pkg::STRM);
    issue_burst(1'b0, 32'h0000_4008, 5, ocp_pkg::STRM);
    issue_burst(1'b1, 32'h0000_5100, 1, ocp_pkg::INCR);
    issue_burst(1'b1, 32'h0000_6200, 6, ocp_pkg::INCR);
    issue_burst(1'b0, 32'h0000_7300, 1, ocp_pkg::INCR);

    // Drain the stream under random tready
    t = 0;
    while (!timed_out && stream_cnt != exp_cnt && t < WAIT_LIMIT) begin
      @(negedge Clk);
      t++;
    end
    if (!timed_out && stream_cnt != exp_cnt) begin
      note_timeout("stream to drain");
    end
    repeat (4) @(negedge Clk);

    $display("Summary: %0d errors, %0d of %0d stream beats seen", err_cnt, stream_cnt, exp_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
hdl/ocp_pkg.sv
hdl/master_cfg_pkg.sv
hdl/ocp_req_if.sv
hdl/ocp_burst_fsm.sv
hdl/burst_counter.sv
hdl/req_datapath.sv
hdl/resp_forward.sv
hdl/ocp_master.sv
tb/ocp_slave_model.sv
tb/ocp_master_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the OCP master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f verilog.f --top-module ocp_master_tb -o ocp_master_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/ocp_master_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Test completed successfully$"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
